//--- analog_format.sv
//--------------------------------------------------------------------------
// picks the channel source and the sync/blank routing for the selected
// format and registers the 6 bit DAC word
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module analog_format (
	input  logic                        i_video_clk,
	input  logic                        i_rst_n,
	input  analogizer_pkg::video_beat_t i_beat,
	input  analogizer_pkg::pixel_t      i_ypbpr,
	output analogizer_pkg::dac_word_t   o_dac
);

	// selected channel source before truncation
	analogizer_pkg::pixel_t    src;
	analogizer_pkg::dac_word_t dac_next;

	always_comb begin
		// defaults are plain RGBS
		src                  = i_beat.pix;
		dac_next.hsync_out   = i_beat.hsync;
		dac_next.sync_out    = 1'b1;
		dac_next.blank_n_out = i_beat.blank_n;

		case (i_beat.mode)
			analogizer_pkg::mode_rgsb: begin
				// sync moves off H to the DAC sync pin
				dac_next.hsync_out = 1'b1;
				dac_next.sync_out  = i_beat.hsync;
			end
			analogizer_pkg::mode_ypbpr: begin
				// converted pixel already holds Pr on R, Y on G and Pb on B
				src                  = i_ypbpr;
				dac_next.hsync_out   = 1'b1;
				dac_next.sync_out    = i_beat.hsync;
				// component needs the DAC running through blanking
				dac_next.blank_n_out = 1'b1;
			end
			analogizer_pkg::mode_yc: begin
				// same as RGBS but never blanked
				dac_next.blank_n_out = 1'b1;
			end
			default: begin
				// mode_rgbs keeps the defaults
			end
		endcase

		// keep top dac_w bits of each channel
		dac_next.r6 = src.r[analogizer_pkg::pixel_w-1 -: analogizer_pkg::dac_w];
		dac_next.g6 = src.g[analogizer_pkg::pixel_w-1 -: analogizer_pkg::dac_w];
		dac_next.b6 = src.b[analogizer_pkg::pixel_w-1 -: analogizer_pkg::dac_w];
	end

	always_ff @(posedge i_video_clk) begin
		if (!i_rst_n) begin
			// black with syncs idle high and blank active
			o_dac.r6          <= '0;
			o_dac.g6          <= '0;
			o_dac.b6          <= '0;
			o_dac.hsync_out   <= 1'b1;
			o_dac.sync_out    <= 1'b1;
			o_dac.blank_n_out <= 1'b0;
		end else begin
			o_dac <= dac_next;
		end
	end

endmodule

//--- analogizer_pkg.sv
//--------------------------------------------------------------------------
// shared widths, colour matrix coefficients and stage types for the
// analogizer video path, referenced by scoped name from every stage
//--------------------------------------------------------------------------
package analogizer_pkg;

	//----------------------------------------------------------------------
	// widths
	//----------------------------------------------------------------------
	// colour channel width coming from the core
	localparam int pixel_w = 8;
	// the DAC only takes the top six bits of each channel
	localparam int dac_w = 6;
	// analog video type code, bit 3 is the pocket-off flag
	localparam int type_code_w = 4;
	// banks 3 and 2 are full bytes, bank 1 only carries b6[5:1]
	localparam int bank_w = 8;
	localparam int bank1_w = 5;

	// matrix arithmetic sizes
	// coefficient and zero-extended pixel both fit a 9 bit signed word
	localparam int coef_w = pixel_w + 1;
	localparam int prod_w = 2 * coef_w;
	// two guard bits for the sum of three products
	localparam int sum_w = prod_w + 2;

	//----------------------------------------------------------------------
	// colour matrix, coefficients scaled by 256
	//----------------------------------------------------------------------
	// luma row
	localparam logic signed [coef_w-1:0] coef_y_r = 9'sd77;
	localparam logic signed [coef_w-1:0] coef_y_g = 9'sd150;
	localparam logic signed [coef_w-1:0] coef_y_b = 9'sd29;
	// blue difference row
	localparam logic signed [coef_w-1:0] coef_pb_r = -9'sd43;
	localparam logic signed [coef_w-1:0] coef_pb_g = -9'sd85;
	localparam logic signed [coef_w-1:0] coef_pb_b = 9'sd128;
	// red difference row
	localparam logic signed [coef_w-1:0] coef_pr_r = 9'sd128;
	localparam logic signed [coef_w-1:0] coef_pr_g = -9'sd107;
	localparam logic signed [coef_w-1:0] coef_pr_b = -9'sd21;
	// mid-scale offset for Pb and Pr after the shift
	localparam logic signed [sum_w-1:0] chroma_offset = 20'sd128;

	// output format, pocket-off codes alias onto these
	typedef enum logic [1:0] {
		mode_rgbs,
		mode_rgsb,
		mode_ypbpr,
		mode_yc
	} video_mode_e;

	//----------------------------------------------------------------------
	// stage types
	//----------------------------------------------------------------------
	typedef struct packed {
		logic [pixel_w-1:0] r;
		logic [pixel_w-1:0] g;
		logic [pixel_w-1:0] b;
	} pixel_t;

	// one pixel with its own controls, passed between stages 1 to 3
	typedef struct packed {
		pixel_t      pix;
		logic        hsync;
		logic        blank_n;
		video_mode_e mode;
	} video_beat_t;

	// what lands on the DAC and sync pins
	typedef struct packed {
		logic [dac_w-1:0] r6;
		logic [dac_w-1:0] g6;
		logic [dac_w-1:0] b6;
		logic             hsync_out;
		logic             sync_out;
		logic             blank_n_out;
	} dac_word_t;

	typedef struct packed {
		logic [bank_w-1:0]  bank3;
		logic [bank_w-1:0]  bank2;
		logic [bank1_w-1:0] bank1;
	} cart_pins_t;

	// idle beat, black and blanked
	localparam video_beat_t beat_idle = '{
		pix: '0,
		hsync: 1'b0,
		blank_n: 1'b0,
		mode: mode_rgbs
	};

endpackage

//--- analogizer_stimulus.dat
// test ena code r g b hsync blank_n, then expected bank3 bank2 bank1 dir
// all fields hex, one vector per line, applied on consecutive clocks
1 1 0 ff 00 00 1 1 ff 40 00 1
1 1 8 00 ff 00 0 1 01 7f 00 1
1 1 0 00 00 ff 1 0 03 80 1f 1
1 1 8 a5 5a c3 0 0 a5 16 18 1
1 1 0 12 34 56 1 1 13 cd 0a 1
2 1 1 ff ff ff 0 1 fe ff 1f 1
2 1 9 80 40 20 1 1 83 50 04 1
2 1 1 7f 81 04 0 0 7e a0 00 1
2 1 9 00 00 00 1 0 03 00 00 1
3 1 2 ff 00 00 1 0 ff d3 0a 1
3 1 a 00 ff 00 0 1 16 65 05 1
3 1 2 00 00 ff 1 1 6b c7 1f 1
3 1 a ff ff ff 0 0 82 7f 10 1
3 1 2 00 00 00 1 1 83 40 10 1
3 1 2 80 80 80 0 1 82 60 10 1
3 1 a ff ff 00 1 0 97 78 00 1
3 1 2 00 ff ff 0 1 02 6c 15 1
3 1 a ff 00 ff 1 1 eb da 1a 1
3 1 2 12 34 56 0 0 6e cb 12 1
4 1 3 ff 00 00 1 0 ff 40 00 1
4 1 4 00 ff 00 0 0 01 7f 00 1
4 1 b 12 34 56 1 0 13 cd 0a 1
4 1 c a5 5a c3 0 0 a5 56 18 1
4 1 5 a5 5a c3 0 0 a5 16 18 1
4 1 f 12 34 56 1 0 13 8d 0a 1
4 1 7 ff ff ff 1 1 ff ff 1f 1
4 1 d 00 00 00 0 0 01 00 00 1
5 0 0 ff ff ff 1 1 00 00 00 0
5 1 0 ff ff ff 1 1 ff ff 1f 1
5 0 2 ff 00 00 1 0 00 00 00 0
5 0 1 80 40 20 1 1 00 00 00 0
5 1 1 80 40 20 1 1 83 50 04 1
5 0 3 12 34 56 0 1 00 00 00 0
6 1 0 12 34 56 1 0 13 8d 0a 1
6 1 1 12 34 56 0 1 12 cd 0a 1
6 1 2 12 34 56 1 0 6f cb 12 1
6 1 3 12 34 56 0 0 11 cd 0a 1
6 1 9 12 34 56 1 0 13 8d 0a 1
6 1 a 12 34 56 0 0 6e cb 12 1
6 1 b 12 34 56 1 0 13 cd 0a 1
6 1 5 12 34 56 0 0 11 8d 0a 1
6 1 a ff 00 00 0 1 fe d3 0a 1
6 1 8 00 ff 00 1 0 03 3f 00 1

//--- analogizer_video.sv
//--------------------------------------------------------------------------
// analogizer video path top; five-cycle pipe from core pixel to
// cartridge port banks, one pixel per clock with no back-pressure
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module analogizer_video (
	input  logic                                   i_video_clk,
	input  logic                                   i_rst_n,
	input  logic                                   i_ena,
	input  logic [analogizer_pkg::type_code_w-1:0] i_type_code,
	input  analogizer_pkg::pixel_t                 i_pix,
	input  logic                                   i_hsync,
	input  logic                                   i_blank_n,
	output analogizer_pkg::cart_pins_t             o_pins,
	output logic                                   o_pins_dir
);

	// stage 1 to 2
	analogizer_pkg::video_beat_t capture_beat;
	// stage 2 to 3, beat and converted pixel aligned
	analogizer_pkg::video_beat_t matrix_beat;
	analogizer_pkg::pixel_t      matrix_ypbpr;
	// stage 3 to 4
	analogizer_pkg::dac_word_t   format_dac;

	// 1 cycle, register and decode mode
	video_mode_capture video_mode_capture_i (
		.i_video_clk (i_video_clk),
		.i_rst_n     (i_rst_n),
		.i_type_code (i_type_code),
		.i_pix       (i_pix),
		.i_hsync     (i_hsync),
		.i_blank_n   (i_blank_n),
		.o_beat      (capture_beat)
	);

	// 2 cycles, colour matrix
	ypbpr_matrix ypbpr_matrix_i (
		.i_video_clk (i_video_clk),
		.i_rst_n     (i_rst_n),
		.i_beat      (capture_beat),
		.o_beat      (matrix_beat),
		.o_ypbpr     (matrix_ypbpr)
	);

	// 1 cycle, format select into the DAC word
	analog_format analog_format_i (
		.i_video_clk (i_video_clk),
		.i_rst_n     (i_rst_n),
		.i_beat      (matrix_beat),
		.i_ypbpr     (matrix_ypbpr),
		.o_dac       (format_dac)
	);

	// 1 cycle, bank packing and enable gating
	cart_bus_driver cart_bus_driver_i (
		.i_video_clk (i_video_clk),
		.i_rst_n     (i_rst_n),
		.i_ena       (i_ena),
		.i_dac       (format_dac),
		.o_pins      (o_pins),
		.o_pins_dir  (o_pins_dir)
	);

endmodule

//--- cart_bus_driver.sv
//--------------------------------------------------------------------------
// last stage, packs the DAC word onto cartridge banks 3, 2 and 1 and
// releases the pins to input while in reset or disabled
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module cart_bus_driver (
	input  logic                      i_video_clk,
	input  logic                      i_rst_n,
	input  logic                      i_ena,
	input  analogizer_pkg::dac_word_t i_dac,
	output analogizer_pkg::cart_pins_t o_pins,
	output logic                      o_pins_dir
);

	analogizer_pkg::cart_pins_t pins_next;

	//----------------------------------------------------------------------
	// pin packing
	//----------------------------------------------------------------------
	always_comb begin
		// bank3: R0..R5 on the upper pins, then HS and the DAC sync pin
		pins_next.bank3 = {i_dac.r6, i_dac.hsync_out, i_dac.sync_out};
		// bank2: B0, /BLANK, then G0..G5
		pins_next.bank2 = {i_dac.b6[0], i_dac.blank_n_out, i_dac.g6};
		// bank1: rest of blue
		pins_next.bank1 = i_dac.b6[analogizer_pkg::dac_w-1:1];
	end

	// disabled or in reset: all banks low and direction back to input
	// so the adapter is not driven
	always_ff @(posedge i_video_clk) begin
		if (!i_rst_n || !i_ena) begin
			o_pins     <= '0;
			o_pins_dir <= 1'b0;
		end else begin
			o_pins     <= pins_next;
			// 1 means output towards the adapter
			o_pins_dir <= 1'b1;
		end
	end

endmodule

//--- files.f
analogizer_pkg.sv
video_mode_capture.sv
ypbpr_matrix.sv
analog_format.sv
cart_bus_driver.sv
analogizer_video.sv
tb_analogizer_video.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the analogizer video testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f \
	--top-module tb_analogizer_video -o sim_analogizer &&
	sim_out="$(./obj_dir/sim_analogizer)" &&
	echo "$sim_out" &&
	grep -q "All tests passed" <<< "$sim_out" ||
	{ echo "simulation failed"; exit 1; }

//--- tb_analogizer_video.sv
//--------------------------------------------------------------------------
// testbench for the analogizer video top that streams vectors from the data
// file and checks the cartridge pins five clocks after each one is driven
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_analogizer_video;

	localparam int clk_period = 8;
	localparam int reset_cycles = 16;
	localparam int latency = 5;
	localparam int num_vectors = 43;
	localparam int num_fields = 12;
	localparam int num_tests = 6;
	// enable is sampled by the last stage only, so it trails its own pixel
	localparam int ena_lag = latency - 1;
	localparam int watchdog_ns = 2 * (reset_cycles + num_vectors + latency) * clk_period;

	logic                                   i_video_clk;
	logic                                   i_rst_n;
	logic                                   i_ena;
	logic [analogizer_pkg::type_code_w-1:0] i_type_code;
	analogizer_pkg::pixel_t                 i_pix;
	logic                                   i_hsync;
	logic                                   i_blank_n;
	analogizer_pkg::cart_pins_t             o_pins;
	logic                                   o_pins_dir;

	// fields per vector are test ena code r g b hsync blank_n bank3 bank2 bank1 dir
	logic [7:0] stim_mem [0:num_vectors*num_fields-1];

	// expected pins in flight with one entry per applied vector
	analogizer_pkg::cart_pins_t exp_pins_q[$];
	logic                       exp_dir_q[$];
	int                         exp_test_q[$];

	int check_count;
	int error_count;
	int cur_test;
	int test_checks [1:num_tests];
	int test_errors [1:num_tests];

	analogizer_video analogizer_video_i (
		.i_video_clk (i_video_clk),
		.i_rst_n     (i_rst_n),
		.i_ena       (i_ena),
		.i_type_code (i_type_code),
		.i_pix       (i_pix),
		.i_hsync     (i_hsync),
		.i_blank_n   (i_blank_n),
		.o_pins      (o_pins),
		.o_pins_dir  (o_pins_dir)
	);

	function automatic logic [7:0] field(input int v, input int idx);
		return stim_mem[v*num_fields + idx];
	endfunction

	function automatic string test_name(input int t);
		case (t)
			1: return "rgbs";
			2: return "rgsb";
			3: return "ypbpr matrix";
			4: return "y/c and undefined codes";
			5: return "enable gating and reset";
			default: return "mode streaming";
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		test_checks[cur_test]++;
		if (got !== exp) begin
			error_count++;
			test_errors[cur_test]++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input int t);
		$display("test %0d %s: %0d checks, %0d errors, %s", t, test_name(t),
			test_checks[t], test_errors[t], (test_errors[t] == 0) ? "ok" : "FAILED");
	endtask

	// drive one vector and queue what the pins must show for it
	task automatic apply_vector(input int v);
		analogizer_pkg::cart_pins_t exp_pins;
		logic [7:0] code_f;
		logic [7:0] bank1_f;
		code_f  = field(v, 2);
		bank1_f = field(v, 10);
		i_type_code <= code_f[analogizer_pkg::type_code_w-1:0];
		i_pix.r     <= field(v, 3);
		i_pix.g     <= field(v, 4);
		i_pix.b     <= field(v, 5);
		i_hsync     <= field(v, 6) != 8'h00;
		i_blank_n   <= field(v, 7) != 8'h00;
		exp_pins.bank3 = field(v, 8);
		exp_pins.bank2 = field(v, 9);
		exp_pins.bank1 = bank1_f[analogizer_pkg::bank1_w-1:0];
		exp_pins_q.push_back(exp_pins);
		exp_dir_q.push_back(field(v, 11) != 8'h00);
		exp_test_q.push_back(int'(field(v, 0)));
	endtask

	task automatic check_vector();
		analogizer_pkg::cart_pins_t exp_pins;
		logic exp_dir;
		exp_pins = exp_pins_q.pop_front();
		exp_dir  = exp_dir_q.pop_front();
		cur_test = exp_test_q.pop_front();
		compare_value("o_pins.bank3", 32'(o_pins.bank3), 32'(exp_pins.bank3));
		compare_value("o_pins.bank2", 32'(o_pins.bank2), 32'(exp_pins.bank2));
		compare_value("o_pins.bank1", 32'(o_pins.bank1), 32'(exp_pins.bank1));
		compare_value("o_pins_dir", 32'(o_pins_dir), 32'(exp_dir));
		// last vector of a test closes it
		if (exp_test_q.size() == 0 || exp_test_q[0] != cur_test) begin
			report_test(cur_test);
		end
	endtask

	initial begin
		i_video_clk = 1'b0;
		forever #(clk_period / 2) i_video_clk = ~i_video_clk;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("Some tests failed");
		$finish;
	end

	initial begin : stimulus
		logic [7:0] ena_f;
		i_rst_n     = 1'b0;
		// enable high through reset so only reset holds the pins off
		i_ena       = 1'b1;
		i_type_code = '0;
		i_pix       = '0;
		i_hsync     = 1'b0;
		i_blank_n   = 1'b0;
		check_count = 0;
		error_count = 0;
		cur_test    = 5;
		for (int t = 1; t <= num_tests; t++) begin
			test_checks[t] = 0;
			test_errors[t] = 0;
		end
		$readmemh("analogizer_stimulus.dat", stim_mem);
		for (int i = 0; i < num_vectors * num_fields; i++) begin
			if ($isunknown(stim_mem[i]) && error_count == 0) begin
				$display("stimulus file is missing or holds fewer values than expected");
				error_count++;
			end
		end

		// pins stay released for every reset cycle
		for (int c = 0; c < reset_cycles; c++) begin
			@(posedge i_video_clk);
			if (c == reset_cycles - 1) begin
				i_rst_n <= 1'b1;
				i_ena   <= 1'b0;
			end
			@(negedge i_video_clk);
			compare_value("o_pins", 32'(o_pins), 32'd0);
			compare_value("o_pins_dir", 32'(o_pins_dir), 32'd0);
		end

		for (int c = 0; c < num_vectors + latency; c++) begin
			@(posedge i_video_clk);
			if (c < num_vectors) begin
				apply_vector(c);
			end
			if (c >= ena_lag && c - ena_lag < num_vectors) begin
				ena_f = field(c - ena_lag, 1);
				i_ena <= ena_f != 8'h00;
			end else begin
				i_ena <= 1'b0;
			end
			// outputs settle well before the falling edge
			@(negedge i_video_clk);
			if (c < latency) begin
				// pipe refilling after reset with enable still low
				cur_test = 5;
				compare_value("o_pins", 32'(o_pins), 32'd0);
				compare_value("o_pins_dir", 32'(o_pins_dir), 32'd0);
			end else begin
				check_vector();
			end
		end

		$display("summary: %0d tests, %0d checks, %0d errors", num_tests, check_count,
			error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- video_mode_capture.sv
//--------------------------------------------------------------------------
// input stage, registers the pixel and its controls and turns the analog
// video type code into an output format for the rest of the pipe
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module video_mode_capture (
	input  logic                                       i_video_clk,
	input  logic                                       i_rst_n,
	input  logic [analogizer_pkg::type_code_w-1:0]     i_type_code,
	input  analogizer_pkg::pixel_t                     i_pix,
	input  logic                                       i_hsync,
	input  logic                                       i_blank_n,
	output analogizer_pkg::video_beat_t                o_beat
);

	analogizer_pkg::video_mode_e mode_dec;

	// code decode
	// bit 3 only turns the pocket screen off, so 8..c alias 0..4
	always_comb begin
		case (i_type_code)
			4'h0, 4'h8: begin
				mode_dec = analogizer_pkg::mode_rgbs;
			end
			4'h1, 4'h9: begin
				// sync goes to the DAC sync pin for sync on green
				mode_dec = analogizer_pkg::mode_rgsb;
			end
			4'h2, 4'ha: begin
				mode_dec = analogizer_pkg::mode_ypbpr;
			end
			4'h3, 4'h4, 4'hb, 4'hc: begin
				// y/c encoder wants continuous video, no blank
				mode_dec = analogizer_pkg::mode_yc;
			end
			default: begin
				// codes with no format fall back to plain RGBS
				mode_dec = analogizer_pkg::mode_rgbs;
			end
		endcase
	end

	// one register stage, everything moves together
	always_ff @(posedge i_video_clk) begin
		if (!i_rst_n) begin
			o_beat <= analogizer_pkg::beat_idle;
		end else begin
			o_beat.pix     <= i_pix;
			o_beat.hsync   <= i_hsync;
			o_beat.blank_n <= i_blank_n;
			o_beat.mode    <= mode_dec;
		end
	end

endmodule

//--- ypbpr_matrix.sv
//--------------------------------------------------------------------------
// two-stage RGB to YPbPr matrix; the original beat is delayed alongside
// so every converted pixel leaves with its own controls and mode
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module ypbpr_matrix (
	input  logic                        i_video_clk,
	input  logic                        i_rst_n,
	input  analogizer_pkg::video_beat_t i_beat,
	output analogizer_pkg::video_beat_t o_beat,
	output analogizer_pkg::pixel_t      o_ypbpr
);

	// channels zero-extended to signed so the negative coefficients work
	logic signed [analogizer_pkg::coef_w-1:0] r_s;
	logic signed [analogizer_pkg::coef_w-1:0] g_s;
	logic signed [analogizer_pkg::coef_w-1:0] b_s;

	// stage 1 products, one per coefficient
	logic signed [analogizer_pkg::prod_w-1:0] p_yr_q, p_yg_q, p_yb_q;
	logic signed [analogizer_pkg::prod_w-1:0] p_pbr_q, p_pbg_q, p_pbb_q;
	logic signed [analogizer_pkg::prod_w-1:0] p_prr_q, p_prg_q, p_prb_q;

	// stage 2 sums and scaled results
	logic signed [analogizer_pkg::sum_w-1:0] y_sum, pb_sum, pr_sum;
	logic signed [analogizer_pkg::sum_w-1:0] y_val, pb_val, pr_val;

	analogizer_pkg::video_beat_t beat_d1;

	// clip a scaled sum into 0..255
	function automatic logic [analogizer_pkg::pixel_w-1:0] clip_pix(
		input logic signed [analogizer_pkg::sum_w-1:0] v
	);
		if (v[analogizer_pkg::sum_w-1]) begin
			// negative
			return '0;
		end else if (|v[analogizer_pkg::sum_w-2:analogizer_pkg::pixel_w]) begin
			// above full scale
			return '1;
		end
		return v[analogizer_pkg::pixel_w-1:0];
	endfunction

	always_comb begin
		r_s = $signed({1'b0, i_beat.pix.r});
		g_s = $signed({1'b0, i_beat.pix.g});
		b_s = $signed({1'b0, i_beat.pix.b});
	end

	//----------------------------------------------------------------------
	// stage 1, nine multiplies
	//----------------------------------------------------------------------
	always_ff @(posedge i_video_clk) begin
		p_yr_q  <= r_s * analogizer_pkg::coef_y_r;
		p_yg_q  <= g_s * analogizer_pkg::coef_y_g;
		p_yb_q  <= b_s * analogizer_pkg::coef_y_b;
		p_pbr_q <= r_s * analogizer_pkg::coef_pb_r;
		p_pbg_q <= g_s * analogizer_pkg::coef_pb_g;
		p_pbb_q <= b_s * analogizer_pkg::coef_pb_b;
		p_prr_q <= r_s * analogizer_pkg::coef_pr_r;
		p_prg_q <= g_s * analogizer_pkg::coef_pr_g;
		p_prb_q <= b_s * analogizer_pkg::coef_pr_b;
	end

	//----------------------------------------------------------------------
	// stage 2, sum, scale back by 256, offset chroma, clip
	//----------------------------------------------------------------------
	always_comb begin
		y_sum  = p_yr_q + p_yg_q + p_yb_q;
		pb_sum = p_pbr_q + p_pbg_q + p_pbb_q;
		pr_sum = p_prr_q + p_prg_q + p_prb_q;
		y_val  = y_sum >>> 8;
		// Pb and Pr are centred on mid-scale
		pb_val = (pb_sum >>> 8) + analogizer_pkg::chroma_offset;
		pr_val = (pr_sum >>> 8) + analogizer_pkg::chroma_offset;
	end

	// packed as r = Pr, g = Y, b = Pb, the order the DAC pins expect
	always_ff @(posedge i_video_clk) begin
		o_ypbpr.r <= clip_pix(pr_val);
		o_ypbpr.g <= clip_pix(y_val);
		o_ypbpr.b <= clip_pix(pb_val);
	end

	// beat delay line, two deep to match the math
	always_ff @(posedge i_video_clk) begin
		if (!i_rst_n) begin
			beat_d1 <= analogizer_pkg::beat_idle;
			o_beat  <= analogizer_pkg::beat_idle;
		end else begin
			beat_d1 <= i_beat;
			o_beat  <= beat_d1;
		end
	end

endmodule
